/* vlog.f */
+incdir+dv
design/isa_pkg.sv
design/mem_pkg.sv
design/alu8.sv
design/prefetch_unit.sv
design/prefetch_queue.sv
design/execute_unit.sv
design/cpu_top.sv
dv/tb_cpu_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_cpu_top -o sim_cpu_top

out=$(./obj_dir/sim_cpu_top)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
	exit 0
else
	exit 1
fi

/* dv/cpu_model.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// Model copy of the data area, so the DUT still sees the original bytes
logic [7:0] model_data [0:255];
logic [15:0] exp_addr [$];
logic [7:0] exp_data [$];
int model_stores;

function automatic bit branch_taken(input logic [7:0] op, input isa_pkg::flag_t f);
	case (op)
		isa_pkg::OP_JRZ_D:  return f.z;
		isa_pkg::OP_JRNZ_D: return !f.z;
		isa_pkg::OP_JRC_D:  return f.c;
		isa_pkg::OP_JRNC_D: return !f.c;
		default:            return 1'b1;
	endcase
endfunction

task automatic alu_model(input logic [7:0] op, input logic [7:0] val,
	inout logic [7:0] acc, inout isa_pkg::flag_t f);
	logic [7:0] b;
	logic cin;
	logic [8:0] full;
	logic [4:0] low;
	int sv;
	b = (op == isa_pkg::OP_SUB_XL_IMMD) ? ~val : val;
	cin = (op == isa_pkg::OP_SUB_XL_IMMD) || (op == isa_pkg::OP_ADC_XL_IMMD && f.c);
	full = {1'b0, acc} + {1'b0, b} + {8'h00, cin};
	low = {1'b0, acc[3:0]} + {1'b0, b[3:0]} + {4'h0, cin};
	sv = int'($signed(acc)) + int'($signed(b)) + int'(cin);
	case (op)
		isa_pkg::OP_AND_XL_IMMD: acc = acc & val;
		isa_pkg::OP_OR_XL_IMMD:  acc = acc | val;
		isa_pkg::OP_XOR_XL_IMMD: acc = acc ^ val;
		default:
		begin
			f.c = full[8];
			f.h = low[4];
			f.o = (sv > 127) || (sv < -128);	// Out of signed byte range
			acc = full[7:0];
		end
	endcase
	f.z = (acc == 8'h00);
	f.n = acc[7];
endtask

// Runs the program at RESET_PC up to its trap
task automatic run_model();
	logic [15:0] pc;
	logic [15:0] dir;
	logic [15:0] step;
	logic [7:0] xl;
	logic [7:0] op;
	logic [7:0] b1;
	isa_pkg::flag_t f;
	int a;
	int n;
	pc = isa_pkg::RESET_PC;
	xl = 8'h00;
	f = '0;
	n = 0;
	exp_addr.delete();
	exp_data.delete();
	for (a = 0; a < 256; a++)
		model_data[a] = mem[a];
	op = mem[pc];
	while (op != isa_pkg::OP_TRAP && n < 200)
	begin
		b1 = mem[pc + 16'd1];
		dir = {mem[pc + 16'd2], b1};
		step = {14'd0, isa_pkg::inst_size(op)};
		case (op)
			isa_pkg::OP_LD_XL_IMMD:
				xl = b1;
			isa_pkg::OP_ADD_XL_IMMD, isa_pkg::OP_ADC_XL_IMMD, isa_pkg::OP_SUB_XL_IMMD,
			isa_pkg::OP_AND_XL_IMMD, isa_pkg::OP_OR_XL_IMMD, isa_pkg::OP_XOR_XL_IMMD:
				alu_model(op, b1, xl, f);
			isa_pkg::OP_JR_D, isa_pkg::OP_JRZ_D, isa_pkg::OP_JRNZ_D, isa_pkg::OP_JRC_D,
			isa_pkg::OP_JRNC_D:
				if (branch_taken(op, f))
					step = {{8{b1[7]}}, b1};
			isa_pkg::OP_LD_XL_DIR:
			begin
				xl = model_data[dir[7:0]];
				f.z = (xl == 8'h00);
				f.n = xl[7];
			end
			isa_pkg::OP_LD_DIR_XL:
			begin
				model_data[dir[7:0]] = xl;
				exp_addr.push_back(dir);
				exp_data.push_back(xl);
			end
			default: ;
		endcase
		pc = pc + step;
		op = mem[pc];
		n++;
	end
	if (op != isa_pkg::OP_TRAP)
	begin
		errors++;
		$display("Model of program %0d never reached its trap", prog);
	end
	model_stores = exp_addr.size();
endtask

`endif

/* dv/tb_cpu_top.sv */
`timescale 1ns/1ns

module tb_cpu_top;

	localparam int NUM_PROGS = 10;
	localparam int NUM_INSTS = 40;
	localparam int CYCLE_LIMIT = NUM_PROGS * (NUM_INSTS * 4 + 30);

	logic clk;
	logic reset = 1'b1;
	mem_pkg::bank_addr_t bank_addr;
	mem_pkg::bank_data_t bank_data;
	logic [15:0] data_addr;
	logic [7:0] data_rdata;
	mem_pkg::data_port_t data_wr;
	logic trap;

	logic [7:0] mem [0:65535];
	int errors = 0;
	int cycles = 0;
	int stores;
	int prog;

	// Weighted toward stores, one unused byte runs as NOP
	logic [7:0] op_menu [0:18] = '{isa_pkg::OP_NOP, isa_pkg::OP_LD_XL_IMMD,
		isa_pkg::OP_ADD_XL_IMMD, isa_pkg::OP_ADC_XL_IMMD, isa_pkg::OP_SUB_XL_IMMD,
		isa_pkg::OP_AND_XL_IMMD, isa_pkg::OP_OR_XL_IMMD, isa_pkg::OP_XOR_XL_IMMD,
		isa_pkg::OP_JR_D, isa_pkg::OP_JRZ_D, isa_pkg::OP_JRNZ_D, isa_pkg::OP_JRC_D,
		isa_pkg::OP_JRNC_D, isa_pkg::OP_LD_XL_DIR, isa_pkg::OP_LD_XL_DIR,
		isa_pkg::OP_LD_DIR_XL, isa_pkg::OP_LD_DIR_XL, isa_pkg::OP_LD_DIR_XL, 8'hA5};
	logic [7:0] cond_jumps [0:3] = '{isa_pkg::OP_JRZ_D, isa_pkg::OP_JRNZ_D,
		isa_pkg::OP_JRC_D, isa_pkg::OP_JRNC_D};

	`include "cpu_model.svh"

	cpu_top i_cpu_top
	(
		.clk(clk),
		.reset(reset),
		.bank_addr(bank_addr),
		.bank_data(bank_data),
		.data_addr(data_addr),
		.data_rdata(data_rdata),
		.data_wr(data_wr),
		.trap(trap)
	);

	// One byte array behind both banks and the data port
	assign bank_data.even = mem[{bank_addr.even, 1'b0}];
	assign bank_data.odd = mem[{bank_addr.odd, 1'b1}];
	assign data_rdata = mem[data_addr];

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Run hit the limit of %0d cycles in program %0d", CYCLE_LIMIT, prog);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic logic [7:0] random_op();
		int pick;
		pick = int'($urandom % 19);
		return op_menu[pick];
	endfunction

	// Groups of load, arithmetic, conditional jump, store
	function automatic logic [7:0] pattern_op(input int i);
		int g;
		g = i / 4;
		case (i % 4)
			0: return isa_pkg::OP_LD_XL_IMMD;
			1: return (g % 2 == 0) ? isa_pkg::OP_SUB_XL_IMMD : isa_pkg::OP_ADD_XL_IMMD;
			2: return cond_jumps[(g / 2) % 4];
			default: return isa_pkg::OP_LD_DIR_XL;
		endcase
	endfunction

	task automatic gen_program(input bit branch_mode);
		logic [7:0] ops [0:NUM_INSTS];
		logic [15:0] addrs [0:NUM_INSTS];
		logic [15:0] a;
		logic [7:0] imm;
		logic [7:0] last_imm;
		int skip;
		int i;
		for (i = 0; i < 256; i++)
			mem[i] = 8'($urandom);
		a = isa_pkg::RESET_PC;
		for (i = 0; i < NUM_INSTS; i++)
		begin
			ops[i] = branch_mode ? pattern_op(i) : random_op();
			addrs[i] = a;
			a = a + {14'd0, isa_pkg::inst_size(ops[i])};
		end
		ops[NUM_INSTS] = isa_pkg::OP_TRAP;
		addrs[NUM_INSTS] = a;
		last_imm = 8'h00;
		for (i = 0; i <= NUM_INSTS; i++)
		begin
			imm = 8'($urandom);
			case (ops[i])
				isa_pkg::OP_JR_D, isa_pkg::OP_JRZ_D, isa_pkg::OP_JRNZ_D, isa_pkg::OP_JRC_D,
				isa_pkg::OP_JRNC_D:
				begin
					skip = int'($urandom % 4);
					if (i + 1 + skip > NUM_INSTS)
						skip = NUM_INSTS - i - 1;	// Never past the trap
					imm = 8'(addrs[i + 1 + skip] - addrs[i]);
				end
				isa_pkg::OP_LD_XL_IMMD:
					last_imm = imm;
				isa_pkg::OP_ADD_XL_IMMD:
					if (branch_mode && $urandom % 2 == 1)
						imm = 8'h00 - last_imm;	// Zero result
				isa_pkg::OP_SUB_XL_IMMD:
					if (branch_mode && $urandom % 2 == 1)
						imm = last_imm;
				default: ;
			endcase
			mem[addrs[i]] = ops[i];
			if (isa_pkg::inst_size(ops[i]) >= 2'd2)
				mem[addrs[i] + 16'd1] = imm;
			if (isa_pkg::inst_size(ops[i]) == 2'd3)
				mem[addrs[i] + 16'd2] = 8'h00;	// Data area in page zero
		end
	endtask

	task automatic check_quiet(input string name);
		if (trap !== 1'b0)
		begin
			errors++;
			$display("[FAIL] %s trap (program %0d) expected 0 actual %b", name, prog, trap);
		end
		if (data_wr.wr !== 1'b0)
		begin
			errors++;
			$display("[FAIL] %s wr (program %0d) expected 0 actual %b", name, prog, data_wr.wr);
		end
	endtask

	task automatic take_store();
		logic [15:0] want_addr;
		logic [7:0] want_data;
		if (exp_addr.size() == 0)
		begin
			errors++;
			$display("Program %0d stored to %h beyond the expected stores", prog, data_wr.addr);
		end
		else
		begin
			want_addr = exp_addr.pop_front();
			want_data = exp_data.pop_front();
			if (data_wr.addr !== want_addr)
			begin
				errors++;
				$display("[FAIL] store_addr (program %0d) expected %h actual %h",
					prog, want_addr, data_wr.addr);
			end
			if (data_wr.data !== want_data)
			begin
				errors++;
				$display("[FAIL] store_data (program %0d) expected %h actual %h",
					prog, want_data, data_wr.data);
			end
		end
		mem[data_wr.addr] = data_wr.data;
		stores++;
	endtask

	initial
	begin
		int a;
		bit halted;
		void'($urandom(97));
		for (a = 0; a < 65536; a++)
			mem[a] = a[15:8] ^ a[7:0];
		for (prog = 0; prog < NUM_PROGS; prog++)
		begin
			@(posedge clk);
			reset <= 1'b1;
			gen_program(prog == 0);	// First program exercises the conditional jumps
			run_model();
			stores = 0;
			@(posedge clk);
			repeat (2)
			begin
				@(negedge clk);
				check_quiet("reset_state");
				@(posedge clk);
			end
			reset <= 1'b0;
			@(negedge clk);
			check_quiet("reset_state");
			@(negedge clk);
			check_quiet("reset_state");
			halted = 1'b0;
			while (!halted)
			begin
				@(negedge clk);
				if (data_wr.wr)
					take_store();
				if (trap)
					halted = 1'b1;
			end
			if (stores != model_stores)
			begin
				errors++;
				$display("[FAIL] store_count (program %0d) expected %0d actual %0d",
					prog, model_stores, stores);
			end
			repeat (20)
			begin
				@(negedge clk);
				if (data_wr.wr !== 1'b0)
				begin
					errors++;
					$display("[FAIL] halt_store (program %0d) expected 0 actual %b",
						prog, data_wr.wr);
				end
				if (trap !== 1'b1)
				begin
					errors++;
					$display("[FAIL] halt_trap (program %0d) expected 1 actual %b", prog, trap);
				end
			end
		end
		$display("Errors: %0d in %0d programs over %0d cycles", errors, NUM_PROGS, cycles);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* design/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top
(
	input  logic                clk,
	input  logic                reset,
	output mem_pkg::bank_addr_t bank_addr,
	input  mem_pkg::bank_data_t bank_data,
	output logic [15:0]         data_addr,
	input  logic [7:0]          data_rdata,
	output mem_pkg::data_port_t data_wr,
	output logic                trap
);

	logic push;
	logic [15:0] push_bytes;
	logic [2:0] queue_free;
	logic [2:0] queue_count;
	logic [23:0] head_bytes;
	logic [1:0] pop_count;
	logic redirect;
	logic [15:0] redirect_pc;

	prefetch_unit i_prefetch_unit
	(
		.clk(clk),
		.reset(reset),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.queue_free(queue_free),
		.bank_addr(bank_addr),
		.bank_data(bank_data),
		.push(push),
		.push_bytes(push_bytes)
	);

	prefetch_queue i_prefetch_queue
	(
		.clk(clk),
		.reset(reset),
		.push(push),
		.push_bytes(push_bytes),
		.pop_count(pop_count),
		.flush(redirect),
		.queue_free(queue_free),
		.queue_count(queue_count),
		.head_bytes(head_bytes)
	);

	execute_unit i_execute_unit
	(
		.clk(clk),
		.reset(reset),
		.queue_count(queue_count),
		.head_bytes(head_bytes),
		.pop_count(pop_count),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.data_addr(data_addr),
		.data_rdata(data_rdata),
		.data_wr(data_wr),
		.trap(trap)
	);

endmodule

/* design/execute_unit.sv */
`timescale 1ns/1ns

module execute_unit
(
	input  logic                clk,
	input  logic                reset,
	input  logic [2:0]          queue_count,
	input  logic [23:0]         head_bytes,
	output logic [1:0]          pop_count,
	output logic                redirect,
	output logic [15:0]         redirect_pc,
	output logic [15:0]         data_addr,
	input  logic [7:0]          data_rdata,
	output mem_pkg::data_port_t data_wr,
	output logic                trap
);

	isa_pkg::opcode_t opcode;
	isa_pkg::flag_t flags_q;
	isa_pkg::flag_t alu_flags;
	logic [15:0] pc_q;
	logic [7:0] xl_q;
	logic [7:0] alu_result;
	logic [7:0] operand;
	logic [7:0] load_data;
	logic [7:0] offset;
	logic [1:0] size;
	logic execute;
	logic taken;

	assign opcode = isa_pkg::opcode_t'(head_bytes[7:0]);
	assign offset = head_bytes[15:8];
	assign size = isa_pkg::inst_size(head_bytes[7:0]);
	assign execute = !trap && (queue_count >= {1'b0, size});
	assign pop_count = execute ? size : 2'd0;

	assign data_addr = head_bytes[23:8];

	// Store still in flight to memory this cycle
	assign load_data = (data_wr.wr && data_wr.addr == data_addr) ? data_wr.data : data_rdata;
	assign operand = (opcode == isa_pkg::OP_LD_XL_DIR) ? load_data : offset;

	always_comb
	begin
		case (opcode)
			isa_pkg::OP_JR_D:   taken = 1'b1;
			isa_pkg::OP_JRZ_D:  taken = flags_q.z;
			isa_pkg::OP_JRNZ_D: taken = !flags_q.z;
			isa_pkg::OP_JRC_D:  taken = flags_q.c;
			isa_pkg::OP_JRNC_D: taken = !flags_q.c;
			default:            taken = 1'b0;
		endcase
	end

	assign redirect = execute && taken;
	assign redirect_pc = pc_q + {{8{offset[7]}}, offset};	// Relative to the branch itself

	alu8 i_alu8
	(
		.op(opcode),
		.acc(xl_q),
		.operand(operand),
		.flags_in(flags_q),
		.result(alu_result),
		.flags_out(alu_flags)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc_q <= isa_pkg::RESET_PC;
			xl_q <= 8'h00;
			flags_q <= '0;
			trap <= 1'b0;
		end
		else if (execute)
		begin
			xl_q <= alu_result;
			flags_q <= alu_flags;
			if (redirect)
				pc_q <= redirect_pc;
			else
				pc_q <= pc_q + {14'd0, size};
			if (opcode == isa_pkg::OP_TRAP)
				trap <= 1'b1;	// Held until reset
		end
	end

	always_ff @(posedge clk)
	begin
		data_wr.addr <= data_addr;
		data_wr.data <= xl_q;
		if (reset)
			data_wr.wr <= 1'b0;
		else
			data_wr.wr <= execute && (opcode == isa_pkg::OP_LD_DIR_XL);
	end

	a_halt_quiet: assert property (@(posedge clk) disable iff (reset)
		trap |-> !data_wr.wr);

endmodule

/* design/prefetch_queue.sv */
`timescale 1ns/1ns

module prefetch_queue
(
	input  logic        clk,
	input  logic        reset,
	input  logic        push,
	input  logic [15:0] push_bytes,
	input  logic [1:0]  pop_count,
	input  logic        flush,
	output logic [2:0]  queue_free,
	output logic [2:0]  queue_count,
	output logic [23:0] head_bytes
);

	logic [3:0][7:0] data_q;
	logic [3:0][7:0] data_next;
	logic [2:0] count_q;
	logic [2:0] remain;

	assign queue_count = count_q;
	assign queue_free = 3'd4 - count_q;
	assign head_bytes = data_q[2:0];	// Oldest byte lowest

	always_comb
	begin
		remain = count_q - {1'b0, pop_count};
		data_next = data_q >> {pop_count, 3'b000};
		// New pair lands right behind what survives the pop
		if (push)
		begin
			data_next[remain[1:0]] = push_bytes[7:0];
			data_next[remain[1:0] + 2'd1] = push_bytes[15:8];
		end
	end

	always_ff @(posedge clk)
	begin
		data_q <= data_next;
		if (reset || flush)
			count_q <= 3'd0;
		else if (push)
			count_q <= remain + 3'd2;
		else
			count_q <= remain;
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		push |-> {1'b0, remain} + 4'd2 <= 4'd4);

	a_no_underflow: assert property (@(posedge clk) disable iff (reset)
		{1'b0, pop_count} <= queue_count);

endmodule

/* design/prefetch_unit.sv */
`timescale 1ns/1ns

module prefetch_unit
(
	input  logic                clk,
	input  logic                reset,
	input  logic                redirect,
	input  logic [15:0]         redirect_pc,
	input  logic [2:0]          queue_free,
	output mem_pkg::bank_addr_t bank_addr,
	input  mem_pkg::bank_data_t bank_data,
	output logic                push,
	output logic [15:0]         push_bytes
);

	logic [15:0] fetch_pc;
	logic [14:0] half_addr;

	assign half_addr = fetch_pc[15:1];

	// Only back-pressure in the core
	assign push = (queue_free >= 3'd2);

	// Unaligned reads take the even byte from the next word
	always_comb
	begin
		if (fetch_pc[0])
		begin
			bank_addr.odd = half_addr;
			bank_addr.even = half_addr + 15'd1;
			push_bytes = {bank_data.even, bank_data.odd};
		end
		else
		begin
			bank_addr.odd = half_addr;
			bank_addr.even = half_addr;
			push_bytes = {bank_data.odd, bank_data.even};
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			fetch_pc <= isa_pkg::RESET_PC;
		else if (redirect)
			fetch_pc <= redirect_pc;	// Push from target next cycle
		else if (push)
			fetch_pc <= fetch_pc + 16'd2;
	end

endmodule

/* design/alu8.sv */
`timescale 1ns/1ns

module alu8
(
	input  isa_pkg::opcode_t op,
	input  logic [7:0]       acc,
	input  logic [7:0]       operand,
	input  isa_pkg::flag_t   flags_in,
	output logic [7:0]       result,
	output isa_pkg::flag_t   flags_out
);

	logic [7:0] addend;
	logic carry_in;
	logic [8:0] sum;
	logic [4:0] half_sum;

	always_comb
	begin
		// Subtract as acc + ~op + 1
		addend = (op == isa_pkg::OP_SUB_XL_IMMD) ? ~operand : operand;
		if (op == isa_pkg::OP_SUB_XL_IMMD)
			carry_in = 1'b1;
		else if (op == isa_pkg::OP_ADC_XL_IMMD)
			carry_in = flags_in.c;
		else
			carry_in = 1'b0;
		sum = {1'b0, acc} + {1'b0, addend} + {8'h00, carry_in};
		half_sum = {1'b0, acc[3:0]} + {1'b0, addend[3:0]} + {4'h0, carry_in};

		result = acc;
		flags_out = flags_in;
		case (op)
			isa_pkg::OP_ADD_XL_IMMD, isa_pkg::OP_ADC_XL_IMMD, isa_pkg::OP_SUB_XL_IMMD:
			begin
				result = sum[7:0];
				flags_out.c = sum[8];
				flags_out.h = half_sum[4];
				flags_out.o = (acc[7] == addend[7]) && (sum[7] != acc[7]);
			end
			isa_pkg::OP_AND_XL_IMMD: result = acc & operand;
			isa_pkg::OP_OR_XL_IMMD:  result = acc | operand;
			isa_pkg::OP_XOR_XL_IMMD: result = acc ^ operand;
			isa_pkg::OP_LD_XL_IMMD, isa_pkg::OP_LD_XL_DIR: result = operand;
			default: result = acc;
		endcase

		if (op inside {isa_pkg::OP_ADD_XL_IMMD, isa_pkg::OP_ADC_XL_IMMD,
			isa_pkg::OP_SUB_XL_IMMD, isa_pkg::OP_AND_XL_IMMD, isa_pkg::OP_OR_XL_IMMD,
			isa_pkg::OP_XOR_XL_IMMD, isa_pkg::OP_LD_XL_DIR})
		begin
			flags_out.z = (result == 8'h00);
			flags_out.n = result[7];
		end
	end

endmodule

/* design/mem_pkg.sv */
package mem_pkg;

	localparam int BANK_AW = 15;

	// Word addresses into the two byte banks
	typedef struct packed
	{
		logic [BANK_AW-1:0] even;
		logic [BANK_AW-1:0] odd;
	} bank_addr_t;

	typedef struct packed
	{
		logic [7:0] even;
		logic [7:0] odd;
	} bank_data_t;

	// Byte store port
	typedef struct packed
	{
		logic [15:0] addr;
		logic [7:0]  data;
		logic        wr;
	} data_port_t;

endpackage

/* design/isa_pkg.sv */
package isa_pkg;

	typedef enum logic [7:0]
	{
		OP_NOP         = 8'h00,
		OP_TRAP        = 8'h01,
		OP_LD_XL_IMMD  = 8'h10,
		OP_ADD_XL_IMMD = 8'h11,
		OP_ADC_XL_IMMD = 8'h12,
		OP_SUB_XL_IMMD = 8'h13,
		OP_AND_XL_IMMD = 8'h14,
		OP_OR_XL_IMMD  = 8'h15,
		OP_XOR_XL_IMMD = 8'h16,
		OP_JR_D        = 8'h20,
		OP_JRZ_D       = 8'h21,
		OP_JRNZ_D      = 8'h22,
		OP_JRC_D       = 8'h23,
		OP_JRNC_D      = 8'h24,
		OP_LD_XL_DIR   = 8'h30,	// Address little-endian
		OP_LD_DIR_XL   = 8'h31
	} opcode_t;

	// Bit 4 down to bit 0
	typedef struct packed
	{
		logic o;	// Overflow
		logic z;	// Zero
		logic n;	// Negative
		logic c;	// Carry
		logic h;	// Half-carry
	} flag_t;

	localparam logic [15:0] RESET_PC = 16'h4000;

	// Unknown bytes count as one-byte NOPs
	function automatic logic [1:0] inst_size(logic [7:0] op);
		case (op)
			OP_LD_XL_DIR, OP_LD_DIR_XL:
				return 2'd3;
			OP_LD_XL_IMMD, OP_ADD_XL_IMMD, OP_ADC_XL_IMMD, OP_SUB_XL_IMMD,
			OP_AND_XL_IMMD, OP_OR_XL_IMMD, OP_XOR_XL_IMMD:
				return 2'd2;
			OP_JR_D, OP_JRZ_D, OP_JRNZ_D, OP_JRC_D, OP_JRNC_D:
				return 2'd2;
			default:
				return 2'd1;
		endcase
	endfunction

endpackage
